// ==== source/fd_config.svh ====
`ifndef FD_CONFIG_SVH
`define FD_CONFIG_SVH

// bridge word and address
`define FD_DATA_W 64
`define FD_ADDR_W 8

// input data word
`define FD_D_W 16

// servings counters in the restaurant record
`define FD_SER_W 8
// servings asked for by one customer
`define FD_REQ_SER_W 4

`endif

// ==== source/fd_pkg.sv ====
`include "fd_config.svh"

package fd_pkg;

	typedef enum logic [3:0] {
		No_action = 4'd0,
		Take      = 4'd1,
		Deliver   = 4'd2,
		Order     = 4'd3,
		Cancel    = 4'd4
	} action_e;

	typedef enum logic [3:0] {
		No_Err        = 4'd0,
		No_Food       = 4'd1,
		D_man_busy    = 4'd2,
		No_customers  = 4'd3,
		Res_busy      = 4'd4,
		Wrong_cancel  = 4'd5,
		Wrong_res_ID  = 4'd6,
		Wrong_food_ID = 4'd7
	} err_e;

	typedef enum logic [1:0] {
		No_food = 2'd0,
		FOOD1   = 2'd1,
		FOOD2   = 2'd2,
		FOOD3   = 2'd3
	} food_e;

	typedef enum logic [1:0] {
		None   = 2'd0,
		Normal = 2'd1,
		VIP    = 2'd3
	} ctm_status_e;

	typedef struct packed {
		ctm_status_e              ctm_status;
		logic [`FD_ADDR_W-1:0]    res_id;
		food_e                    food_id;
		logic [`FD_REQ_SER_W-1:0] ser_food;
	} ctm_info_t;

	typedef struct packed {
		food_e                    food_id;
		logic [`FD_REQ_SER_W-1:0] ser_food;
	} food_ser_t;

	// slot1 sits in the upper half
	typedef struct packed {
		ctm_info_t slot1;
		ctm_info_t slot2;
	} dman_info_t;

	typedef struct packed {
		logic [`FD_SER_W-1:0] limit_num_orders;
		logic [`FD_SER_W-1:0] ser_food1;
		logic [`FD_SER_W-1:0] ser_food2;
		logic [`FD_SER_W-1:0] ser_food3;
	} res_info_t;

	typedef struct packed {
		dman_info_t dman;
		res_info_t  res;
	} dram_word_t;

	// one input word, decoded by whichever strobe is high
	typedef union packed {
		struct packed {
			logic [`FD_D_W-5:0] pad;
			action_e            act;
		} d_act;
		struct packed {
			logic [`FD_D_W-`FD_ADDR_W-1:0] pad;
			logic [`FD_ADDR_W-1:0]         id;
		} d_id;
		struct packed {
			logic [`FD_D_W-`FD_ADDR_W-1:0] pad;
			logic [`FD_ADDR_W-1:0]         id;
		} d_res_id;
		ctm_info_t d_ctm_info;
		struct packed {
			logic [`FD_D_W-7:0] pad;
			food_ser_t          fs;
		} d_food_ser;
	} in_data_u;

	typedef enum logic [1:0] {
		DMAN = 2'd0,
		RES  = 2'd1,
		BOTH = 2'd2
	} wr_kind_e;

endpackage

// ==== source/fd_order_capture.sv ====
`timescale 1ns/1ps
`include "fd_config.svh"

module fd_order_capture import fd_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  act_valid,
	input  logic                  id_valid,
	input  logic                  res_valid,
	input  logic                  cus_valid,
	input  logic                  food_valid,
	input  in_data_u              d,
	output action_e               action,
	output logic [`FD_ADDR_W-1:0] dman_addr,
	output logic [`FD_ADDR_W-1:0] res_addr,
	output ctm_info_t             cus,
	output food_ser_t             food,
	output logic                  ready
);

	logic [`FD_ADDR_W-1:0] res_id;
	logic                  final_in;

	// ids persist across actions so optional strobes can be skipped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			action    <= No_action;
			dman_addr <= '0;
			res_id    <= '0;
			cus       <= '0;
			food      <= '0;
		end else begin
			if (act_valid)
				action <= d.d_act.act;
			if (id_valid)
				dman_addr <= d.d_id.id;
			if (res_valid)
				res_id <= d.d_res_id.id;
			if (cus_valid)
				cus <= d.d_ctm_info;
			if (food_valid)
				food <= d.d_food_ser.fs;
		end
	end

	// last strobe of each action
	always_comb begin
		case (action)
			Take:            final_in = cus_valid;
			Deliver, Cancel: final_in = id_valid;
			Order:           final_in = food_valid;
			default:         final_in = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ready <= 1'b0;
		else
			ready <= final_in;
	end

	assign res_addr = (action == Take) ? cus.res_id : res_id;

endmodule

// ==== source/fd_ctrl.sv ====
`timescale 1ns/1ps
`include "fd_config.svh"

module fd_ctrl import fd_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ready,
	input  action_e               action,
	input  logic [`FD_ADDR_W-1:0] dman_addr,
	input  logic [`FD_ADDR_W-1:0] res_addr,
	input  logic                  complete,
	input  dram_word_t            wr_dman_word,
	input  dram_word_t            wr_res_word,
	input  dram_word_t            wr_both_word,
	input  logic                  C_out_valid,
	output logic                  load_dman,
	output logic                  load_res,
	output logic                  exe,
	output logic                  C_in_valid,
	output logic                  C_r_wb,
	output logic [`FD_ADDR_W-1:0] C_addr,
	output dram_word_t            C_data_w,
	output logic                  out_valid
);

	typedef enum logic [3:0] {
		st_idle, st_rd_dman, st_rd_dman_w, st_rd_res, st_rd_res_w, st_exe,
		st_wr_dman, st_wr_dman_w, st_wr_res, st_wr_res_w, st_out
	} state_e;

	state_e   state;
	state_e   state_nxt;
	logic     shared;
	logic     rd_req;
	logic     wr_req;
	wr_kind_e wr_kind;

	// ========================================
	// state machine
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= st_idle;
		else
			state <= state_nxt;
	end

	// take with one word holding both records
	assign shared = (action == Take) && (dman_addr == res_addr);

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:
				if (ready)
					state_nxt = (action == Order) ? st_rd_res : st_rd_dman;
			st_rd_dman:   state_nxt = st_rd_dman_w;
			st_rd_dman_w:
				if (C_out_valid)
					state_nxt = (action == Take && !shared) ? st_rd_res : st_exe;
			st_rd_res:    state_nxt = st_rd_res_w;
			st_rd_res_w:
				if (C_out_valid)
					state_nxt = st_exe;
			st_exe:       state_nxt = (action == Order) ? st_wr_res : st_wr_dman;
			// result is registered by now, a failed action writes nothing
			st_wr_dman:   state_nxt = complete ? st_wr_dman_w : st_idle;
			st_wr_dman_w:
				if (C_out_valid)
					state_nxt = (action == Take && !shared) ? st_wr_res : st_out;
			st_wr_res:    state_nxt = complete ? st_wr_res_w : st_idle;
			st_wr_res_w:
				if (C_out_valid)
					state_nxt = st_out;
			st_out:       state_nxt = st_idle;
			default:      state_nxt = st_idle;
		endcase
	end

	// ========================================
	// bridge side
	// ========================================
	assign rd_req = (state == st_rd_dman) || (state == st_rd_res);
	assign wr_req = ((state == st_wr_dman) || (state == st_wr_res)) && complete;

	assign C_in_valid = rd_req || wr_req;
	assign C_r_wb     = rd_req;
	assign C_addr     = (state == st_rd_res || state == st_wr_res) ? res_addr : dman_addr;

	always_comb begin
		if (state == st_wr_res)
			wr_kind = RES;
		else if (shared)
			wr_kind = BOTH;
		else
			wr_kind = DMAN;
	end

	always_comb begin
		case (wr_kind)
			RES:     C_data_w = wr_res_word;
			BOTH:    C_data_w = wr_both_word;
			default: C_data_w = wr_dman_word;
		endcase
	end

	// ========================================
	// strobes to the datapath
	// ========================================
	assign load_dman = (state == st_rd_dman_w) && C_out_valid;
	assign load_res  = ((state == st_rd_res_w) && C_out_valid) || (load_dman && shared);
	assign exe       = (state == st_exe);

	assign out_valid = (state == st_out) ||
		(((state == st_wr_dman) || (state == st_wr_res)) && !complete);

endmodule

// ==== source/fd_exec.sv ====
`timescale 1ns/1ps
`include "fd_config.svh"

module fd_exec import fd_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  exe,
	input  action_e               action,
	input  ctm_info_t             cus,
	input  food_ser_t             food,
	input  logic [`FD_ADDR_W-1:0] res_addr,
	input  dman_info_t            dman,
	input  res_info_t             res,
	output dman_info_t            new_dman,
	output res_info_t             new_res,
	output err_e                  err_msg,
	output logic                  complete,
	output logic [`FD_DATA_W-1:0] out_info
);

	logic                  s1_occ;
	logic                  s2_occ;
	logic                  res_hit1;
	logic                  res_hit2;
	logic                  match1;
	logic                  match2;
	logic [`FD_SER_W-1:0]  avail;
	logic [`FD_SER_W+1:0]  booked;
	err_e                  err_nxt;
	logic [`FD_DATA_W-1:0] info_nxt;

	assign s1_occ   = (dman.slot1.ctm_status != None);
	assign s2_occ   = (dman.slot2.ctm_status != None);
	assign res_hit1 = s1_occ && (dman.slot1.res_id == res_addr);
	assign res_hit2 = s2_occ && (dman.slot2.res_id == res_addr);
	assign match1   = res_hit1 && (dman.slot1.food_id == food.food_id);
	assign match2   = res_hit2 && (dman.slot2.food_id == food.food_id);

	// servings already promised, wide enough not to wrap
	assign booked = res.ser_food1 + res.ser_food2 + res.ser_food3;

	always_comb begin
		case (cus.food_id)
			FOOD1:   avail = res.ser_food1;
			FOOD2:   avail = res.ser_food2;
			FOOD3:   avail = res.ser_food3;
			default: avail = '0;
		endcase
	end

	// ========================================
	// business rules
	// ========================================
	always_comb begin
		err_nxt  = No_Err;
		new_dman = dman;
		new_res  = res;
		case (action)
			Take: begin
				if (s1_occ && s2_occ) begin
					err_nxt = D_man_busy;
				end else if (avail < cus.ser_food) begin
					err_nxt = No_Food;
				end else begin
					case (cus.food_id)
						FOOD1:   new_res.ser_food1 = res.ser_food1 - cus.ser_food;
						FOOD2:   new_res.ser_food2 = res.ser_food2 - cus.ser_food;
						FOOD3:   new_res.ser_food3 = res.ser_food3 - cus.ser_food;
						default: new_res = res;
					endcase
					if (!s1_occ) begin
						new_dman.slot1 = cus;
						new_dman.slot2 = '0;
					end else if (dman.slot1.ctm_status != VIP && cus.ctm_status == VIP) begin
						// vip jumps ahead of a normal customer
						new_dman.slot1 = cus;
						new_dman.slot2 = dman.slot1;
					end else begin
						new_dman.slot2 = cus;
					end
				end
			end
			Deliver: begin
				if (!s1_occ && !s2_occ) begin
					err_nxt = No_customers;
				end else begin
					new_dman.slot1 = dman.slot2;
					new_dman.slot2 = '0;
				end
			end
			Order: begin
				if (res.limit_num_orders < booked + food.ser_food) begin
					err_nxt = Res_busy;
				end else begin
					case (food.food_id)
						FOOD1:   new_res.ser_food1 = res.ser_food1 + food.ser_food;
						FOOD2:   new_res.ser_food2 = res.ser_food2 + food.ser_food;
						FOOD3:   new_res.ser_food3 = res.ser_food3 + food.ser_food;
						default: new_res = res;
					endcase
				end
			end
			Cancel: begin
				if (!s1_occ) begin
					err_nxt = Wrong_cancel;
				end else if (!res_hit1 && !res_hit2) begin
					err_nxt = Wrong_res_ID;
				end else if (!match1 && !match2) begin
					err_nxt = Wrong_food_ID;
				end else begin
					// compact toward slot1
					new_dman.slot1 = match1 ? (match2 ? '0 : dman.slot2) : dman.slot1;
					new_dman.slot2 = '0;
				end
			end
			default: err_nxt = No_Err;
		endcase
	end

	always_comb begin
		case (action)
			Take:            info_nxt = {new_dman, new_res};
			Order:           info_nxt = {{$bits(dman_info_t){1'b0}}, new_res};
			Deliver, Cancel: info_nxt = {new_dman, {$bits(res_info_t){1'b0}}};
			default:         info_nxt = '0;
		endcase
		if (err_nxt != No_Err)
			info_nxt = '0;
	end

	// ========================================
	// result registers
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			err_msg  <= No_Err;
			complete <= 1'b0;
			out_info <= '0;
		end else if (exe) begin
			err_msg  <= err_nxt;
			complete <= (err_nxt == No_Err) && (action != No_action);
			out_info <= info_nxt;
		end
	end

endmodule

// ==== source/fd_record_store.sv ====
`timescale 1ns/1ps
`include "fd_config.svh"

module fd_record_store import fd_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       load_dman,
	input  logic       load_res,
	input  logic       exe,
	input  dram_word_t C_data_r,
	input  dman_info_t new_dman,
	input  res_info_t  new_res,
	output dman_info_t dman,
	output res_info_t  res,
	output dram_word_t wr_dman_word,
	output dram_word_t wr_res_word,
	output dram_word_t wr_both_word
);

	dram_word_t dman_word;
	dram_word_t res_word;

	// whole words kept so the other half goes back untouched
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dman_word <= '0;
			res_word  <= '0;
		end else begin
			if (load_dman)
				dman_word <= C_data_r;
			else if (exe)
				dman_word.dman <= new_dman;
			if (load_res)
				res_word <= C_data_r;
			else if (exe)
				res_word.res <= new_res;
		end
	end

	assign dman = dman_word.dman;
	assign res  = res_word.res;

	assign wr_dman_word = dman_word;
	assign wr_res_word  = res_word;
	// shared address, both updated halves in one word
	assign wr_both_word = {dman_word.dman, res_word.res};

endmodule

// ==== source/fd_top.sv ====
`timescale 1ns/1ps
`include "fd_config.svh"

module fd_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  act_valid,
	input  logic                  id_valid,
	input  logic                  res_valid,
	input  logic                  cus_valid,
	input  logic                  food_valid,
	input  fd_pkg::in_data_u      d,
	input  logic                  C_out_valid,
	input  fd_pkg::dram_word_t    C_data_r,
	output logic                  C_in_valid,
	output logic                  C_r_wb,
	output logic [`FD_ADDR_W-1:0] C_addr,
	output fd_pkg::dram_word_t    C_data_w,
	output logic                  out_valid,
	output fd_pkg::err_e          err_msg,
	output logic                  complete,
	output logic [`FD_DATA_W-1:0] out_info
);

	fd_pkg::action_e       action;
	logic [`FD_ADDR_W-1:0] dman_addr;
	logic [`FD_ADDR_W-1:0] res_addr;
	fd_pkg::ctm_info_t     cus;
	fd_pkg::food_ser_t     food;
	logic                  ready;
	logic                  load_dman;
	logic                  load_res;
	logic                  exe;
	fd_pkg::dman_info_t    dman;
	fd_pkg::res_info_t     res;
	fd_pkg::dman_info_t    new_dman;
	fd_pkg::res_info_t     new_res;
	fd_pkg::dram_word_t    wr_dman_word;
	fd_pkg::dram_word_t    wr_res_word;
	fd_pkg::dram_word_t    wr_both_word;

	fd_order_capture capture_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.act_valid  (act_valid),
		.id_valid   (id_valid),
		.res_valid  (res_valid),
		.cus_valid  (cus_valid),
		.food_valid (food_valid),
		.d          (d),
		.action     (action),
		.dman_addr  (dman_addr),
		.res_addr   (res_addr),
		.cus        (cus),
		.food       (food),
		.ready      (ready)
	);

	fd_ctrl ctrl_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.ready        (ready),
		.action       (action),
		.dman_addr    (dman_addr),
		.res_addr     (res_addr),
		.complete     (complete),
		.wr_dman_word (wr_dman_word),
		.wr_res_word  (wr_res_word),
		.wr_both_word (wr_both_word),
		.C_out_valid  (C_out_valid),
		.load_dman    (load_dman),
		.load_res     (load_res),
		.exe          (exe),
		.C_in_valid   (C_in_valid),
		.C_r_wb       (C_r_wb),
		.C_addr       (C_addr),
		.C_data_w     (C_data_w),
		.out_valid    (out_valid)
	);

	fd_exec exec_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.exe      (exe),
		.action   (action),
		.cus      (cus),
		.food     (food),
		.res_addr (res_addr),
		.dman     (dman),
		.res      (res),
		.new_dman (new_dman),
		.new_res  (new_res),
		.err_msg  (err_msg),
		.complete (complete),
		.out_info (out_info)
	);

	fd_record_store store_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.load_dman    (load_dman),
		.load_res     (load_res),
		.exe          (exe),
		.C_data_r     (C_data_r),
		.new_dman     (new_dman),
		.new_res      (new_res),
		.dman         (dman),
		.res          (res),
		.wr_dman_word (wr_dman_word),
		.wr_res_word  (wr_res_word),
		.wr_both_word (wr_both_word)
	);

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	// 20 ns period
	initial clk = 1'b0;
	always #10 clk = ~clk;

	initial begin
		rst_n = 1'b0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// ==== tb/fd_dram_model.sv ====
`timescale 1ns/1ps
`include "fd_config.svh"

module fd_dram_model import fd_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  C_in_valid,
	input  logic                  C_r_wb,
	input  logic [`FD_ADDR_W-1:0] C_addr,
	input  dram_word_t            C_data_w,
	output logic                  C_out_valid,
	output dram_word_t            C_data_r
);

	dram_word_t            mem [0:255];
	int                    wr_count;
	logic                  busy;
	logic [2:0]            wait_cnt;
	logic [`FD_ADDR_W-1:0] req_addr;

	// ========================================
	// initial contents
	// ========================================
	initial begin
		void'($urandom(32'hbf88_9d48));
		for (int a = 0; a < 256; a++)
			mem[a] = {8{8'(a)}};
		// delivery men
		mem[8'h10] = 64'h0000_0000_3205_0505;
		mem[8'h11] = 64'h4821_0000_0000_0000;
		mem[8'h12] = 64'h4812_c871_0000_0000;
		mem[8'h13] = 64'hc813_4862_0000_0000;
		mem[8'h14] = 64'h0000_0000_0f0f_0f0f;
		// restaurants
		mem[8'h20] = 64'h1234_5678_280a_0300;
		mem[8'h21] = 64'h0000_0000_0a04_0302;
		// both records at one address
		mem[8'h30] = 64'h0000_0000_1406_0000;
		C_out_valid = 1'b0;
		C_data_r    = '0;
	end

	// one request at a time, answered after 1 to 4 cycles
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy        <= 1'b0;
			wait_cnt    <= '0;
			req_addr    <= '0;
			wr_count    <= 0;
			C_out_valid <= 1'b0;
			C_data_r    <= '0;
		end else begin
			C_out_valid <= 1'b0;
			if (C_in_valid && !busy) begin
				busy     <= 1'b1;
				wait_cnt <= 3'($urandom % 4);
				req_addr <= C_addr;
				if (!C_r_wb) begin
					mem[C_addr] <= C_data_w;
					wr_count    <= wr_count + 1;
				end
			end else if (busy) begin
				if (wait_cnt == 3'd0) begin
					busy        <= 1'b0;
					C_out_valid <= 1'b1;
					C_data_r    <= mem[req_addr];
				end else begin
					wait_cnt <= wait_cnt - 3'd1;
				end
			end
		end
	end

endmodule

// ==== tb/tb_top.sv ====
`timescale 1ns/1ps
`include "fd_config.svh"

module tb_top import fd_pkg::*; ();

	localparam int NUM_ROWS = 17;
	localparam int OUT_TIMEOUT = 200;

	typedef enum {S_ACT, S_ID, S_RES, S_CUS, S_FOOD} strobe_e;

	// one transaction and its expected result
	typedef struct packed {
		action_e              act;
		logic                 use_id;
		logic [7:0]           id;
		logic                 use_res;
		logic [7:0]           res;
		ctm_info_t            cus;
		food_ser_t            fs;
		err_e                 err;
		logic                 cmp;
		logic [1:0]           n_wr;
		logic [`FD_DATA_W-1:0] info;
	} txn_t;

	logic                  clk;
	logic                  rst_n;
	logic                  act_valid;
	logic                  id_valid;
	logic                  res_valid;
	logic                  cus_valid;
	logic                  food_valid;
	in_data_u              d;
	logic                  C_out_valid;
	dram_word_t            C_data_r;
	logic                  C_in_valid;
	logic                  C_r_wb;
	logic [`FD_ADDR_W-1:0] C_addr;
	dram_word_t            C_data_w;
	logic                  out_valid;
	err_e                  err_msg;
	logic                  complete;
	logic [`FD_DATA_W-1:0] out_info;

	int   errors;
	logic timed_out;
	txn_t rows [NUM_ROWS];

	tb_clk_gen clk_i (.clk(clk), .rst_n(rst_n));

	fd_top dut_i (
		.clk(clk), .rst_n(rst_n),
		.act_valid(act_valid), .id_valid(id_valid), .res_valid(res_valid),
		.cus_valid(cus_valid), .food_valid(food_valid), .d(d),
		.C_out_valid(C_out_valid), .C_data_r(C_data_r),
		.C_in_valid(C_in_valid), .C_r_wb(C_r_wb), .C_addr(C_addr), .C_data_w(C_data_w),
		.out_valid(out_valid), .err_msg(err_msg), .complete(complete), .out_info(out_info)
	);

	fd_dram_model dram_i (
		.clk(clk), .rst_n(rst_n),
		.C_in_valid(C_in_valid), .C_r_wb(C_r_wb), .C_addr(C_addr), .C_data_w(C_data_w),
		.C_out_valid(C_out_valid), .C_data_r(C_data_r)
	);

	function automatic ctm_info_t cust(ctm_status_e st, logic [7:0] rid, food_e f,
			logic [3:0] n);
		cust = '{st, rid, f, n};
	endfunction

	function automatic food_ser_t fser(food_e f, logic [3:0] n);
		fser = '{f, n};
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// strobe high for one cycle, set and cleared on falling edges
	task automatic drive_strobe(input strobe_e sel, input in_data_u word);
		d          = word;
		act_valid  = (sel == S_ACT);
		id_valid   = (sel == S_ID);
		res_valid  = (sel == S_RES);
		cus_valid  = (sel == S_CUS);
		food_valid = (sel == S_FOOD);
		@(negedge clk);
		act_valid  = 1'b0;
		id_valid   = 1'b0;
		res_valid  = 1'b0;
		cus_valid  = 1'b0;
		food_valid = 1'b0;
		d          = '0;
	endtask

	task automatic send_row(input txn_t t);
		in_data_u w;
		@(negedge clk);
		w = '0;
		w.d_act.act = t.act;
		drive_strobe(S_ACT, w);
		if (t.use_res && (t.act == Order || t.act == Cancel)) begin
			w = '0;
			w.d_res_id.id = t.res;
			drive_strobe(S_RES, w);
		end
		if (t.act == Order || t.act == Cancel) begin
			w = '0;
			w.d_food_ser.fs = t.fs;
			drive_strobe(S_FOOD, w);
		end
		if (t.use_id) begin
			w = '0;
			w.d_id.id = t.id;
			drive_strobe(S_ID, w);
		end
		if (t.act == Take) begin
			w = '0;
			w.d_ctm_info = t.cus;
			drive_strobe(S_CUS, w);
		end
	endtask

	task automatic wait_out_valid(output logic late);
		int cycles;
		cycles = 0;
		while (!out_valid && cycles < OUT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		late = !out_valid;
	endtask

	// ========================================
	// transactions, worked out from the initial memory
	// ========================================
	initial begin
		rows[0]  = '{Take, 1'b1, 8'h10, 1'b0, 8'h00, cust(Normal, 8'h20, FOOD1, 4),
			fser(No_food, 0), No_Err, 1'b1, 2'd2,
			{cust(Normal, 8'h20, FOOD1, 4), 16'h0, 32'h2806_0300}};
		rows[1]  = '{Take, 1'b1, 8'h11, 1'b0, 8'h00, cust(VIP, 8'h20, FOOD2, 2),
			fser(No_food, 0), No_Err, 1'b1, 2'd2,
			{cust(VIP, 8'h20, FOOD2, 2), cust(Normal, 8'h20, FOOD2, 1), 32'h2806_0100}};
		rows[2]  = '{Take, 1'b1, 8'h12, 1'b0, 8'h00, cust(Normal, 8'h20, FOOD1, 1),
			fser(No_food, 0), D_man_busy, 1'b0, 2'd0, 64'h0};
		rows[3]  = '{Take, 1'b1, 8'h10, 1'b0, 8'h00, cust(Normal, 8'h20, FOOD3, 5),
			fser(No_food, 0), No_Food, 1'b0, 2'd0, 64'h0};
		rows[4]  = '{Order, 1'b0, 8'h00, 1'b1, 8'h21, 16'h0, fser(FOOD1, 1),
			No_Err, 1'b1, 2'd1, {32'h0, 32'h0a05_0302}};
		rows[5]  = '{Order, 1'b0, 8'h00, 1'b1, 8'h20, 16'h0, fser(FOOD3, 4),
			No_Err, 1'b1, 2'd1, {32'h0, 32'h2806_0104}};
		// no res strobe, restaurant 20 again
		rows[6]  = '{Order, 1'b0, 8'h00, 1'b0, 8'h00, 16'h0, fser(FOOD2, 15),
			No_Err, 1'b1, 2'd1, {32'h0, 32'h2806_1004}};
		rows[7]  = '{Order, 1'b0, 8'h00, 1'b1, 8'h21, 16'h0, fser(FOOD2, 1),
			Res_busy, 1'b0, 2'd0, 64'h0};
		rows[8]  = '{Deliver, 1'b1, 8'h11, 1'b0, 8'h00, 16'h0, fser(No_food, 0),
			No_Err, 1'b1, 2'd1, {cust(Normal, 8'h20, FOOD2, 1), 16'h0, 32'h0}};
		rows[9]  = '{Deliver, 1'b1, 8'h14, 1'b0, 8'h00, 16'h0, fser(No_food, 0),
			No_customers, 1'b0, 2'd0, 64'h0};
		rows[10] = '{Cancel, 1'b1, 8'h14, 1'b1, 8'h20, 16'h0, fser(FOOD1, 0),
			Wrong_cancel, 1'b0, 2'd0, 64'h0};
		rows[11] = '{Cancel, 1'b1, 8'h13, 1'b1, 8'h22, 16'h0, fser(FOOD1, 0),
			Wrong_res_ID, 1'b0, 2'd0, 64'h0};
		rows[12] = '{Cancel, 1'b1, 8'h13, 1'b1, 8'h21, 16'h0, fser(FOOD1, 0),
			Wrong_food_ID, 1'b0, 2'd0, 64'h0};
		rows[13] = '{Cancel, 1'b1, 8'h13, 1'b1, 8'h20, 16'h0, fser(FOOD1, 0),
			No_Err, 1'b1, 2'd1, {cust(Normal, 8'h21, FOOD2, 2), 16'h0, 32'h0}};
		// delivery man and restaurant share word 30
		rows[14] = '{Take, 1'b1, 8'h30, 1'b0, 8'h00, cust(Normal, 8'h30, FOOD1, 2),
			fser(No_food, 0), No_Err, 1'b1, 2'd1,
			{cust(Normal, 8'h30, FOOD1, 2), 16'h0, 32'h1404_0000}};
		rows[15] = '{Take, 1'b0, 8'h00, 1'b0, 8'h00, cust(VIP, 8'h20, FOOD1, 1),
			fser(No_food, 0), No_Err, 1'b1, 2'd2,
			{cust(VIP, 8'h20, FOOD1, 1), cust(Normal, 8'h30, FOOD1, 2), 32'h2805_1004}};
		rows[16] = '{Take, 1'b1, 8'h10, 1'b0, 8'h00, cust(Normal, 8'h21, FOOD3, 2),
			fser(No_food, 0), No_Err, 1'b1, 2'd2,
			{cust(Normal, 8'h20, FOOD1, 4), cust(Normal, 8'h21, FOOD3, 2), 32'h0a05_0300}};
	end

	// ========================================
	// run
	// ========================================
	initial begin
		int   i;
		int   cycles;
		int   wr_before;
		logic late;
		act_valid  = 1'b0;
		id_valid   = 1'b0;
		res_valid  = 1'b0;
		cus_valid  = 1'b0;
		food_valid = 1'b0;
		d          = '0;
		errors     = 0;
		timed_out  = 1'b0;
		cycles     = 0;
		while (rst_n !== 1'b1 && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		if (rst_n !== 1'b1) begin
			$display("reset was never released");
			timed_out = 1'b1;
			errors++;
		end else begin
			@(negedge clk);
			check("out_valid after reset", 64'(out_valid), 64'h0);
			check("C_in_valid after reset", 64'(C_in_valid), 64'h0);
			check("complete after reset", 64'(complete), 64'h0);
			check("err_msg after reset", 64'(err_msg), 64'(No_Err));
		end

		i = 0;
		while (i < NUM_ROWS && !timed_out) begin
			wr_before = dram_i.wr_count;
			send_row(rows[i]);
			wait_out_valid(late);
			if (late) begin
				$display("no out_valid within %0d cycles for row %0d", OUT_TIMEOUT, i);
				timed_out = 1'b1;
				errors++;
			end else begin
				check($sformatf("row %0d err_msg", i), 64'(err_msg), 64'(rows[i].err));
				check($sformatf("row %0d complete", i), 64'(complete), 64'(rows[i].cmp));
				check($sformatf("row %0d out_info", i), out_info, rows[i].info);
				check($sformatf("row %0d writes", i), 64'(dram_i.wr_count - wr_before),
					64'(rows[i].n_wr));
			end
			i++;
		end

		// final memory words
		if (!timed_out) begin
			check("mem 10", dram_i.mem[8'h10],
				{cust(Normal, 8'h20, FOOD1, 4), cust(Normal, 8'h21, FOOD3, 2), 32'h3205_0505});
			check("mem 11", dram_i.mem[8'h11], {cust(Normal, 8'h20, FOOD2, 1), 48'h0});
			check("mem 12", dram_i.mem[8'h12], 64'h4812_c871_0000_0000);
			check("mem 13", dram_i.mem[8'h13], {cust(Normal, 8'h21, FOOD2, 2), 48'h0});
			check("mem 14", dram_i.mem[8'h14], 64'h0000_0000_0f0f_0f0f);
			check("mem 20", dram_i.mem[8'h20], 64'h1234_5678_2805_1004);
			check("mem 21", dram_i.mem[8'h21], 64'h0000_0000_0a05_0300);
			check("mem 30", dram_i.mem[8'h30],
				{cust(VIP, 8'h20, FOOD1, 1), cust(Normal, 8'h30, FOOD1, 2), 32'h1404_0000});
		end

		$display("run finished with %0d errors", errors);
		if (errors == 0 && !timed_out)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+source
source/fd_pkg.sv
source/fd_order_capture.sv
source/fd_ctrl.sv
source/fd_exec.sv
source/fd_record_store.sv
source/fd_top.sv
tb/tb_clk_gen.sv
tb/fd_dram_model.sv
tb/tb_top.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_top
FILELIST := sim.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := TEST PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with $(SIM), run it and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
